//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

	parameter int xlen = 64;

	typedef logic [4:0] reg_addr_t;

	// major opcodes, RISC-V encodings
	typedef enum logic [6:0] {
		OP_NONE = 7'b0000000,
		OP_IMM  = 7'b0010011,
		OP      = 7'b0110011,
		LUI     = 7'b0110111,
		LOAD    = 7'b0000011,
		STORE   = 7'b0100011,
		BRANCH  = 7'b1100011,
		JAL     = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	typedef struct packed {
		logic    regwrite;
		logic    memread;
		logic    memwrite;
		logic    branch;
		logic    jump;
		alu_op_t alu_op;
		logic    use_imm;
	} ctrl_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [31:0]     instruction;
	} fetch_data_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [31:0]     instruction;
		ctrl_t           ctrl;
		reg_addr_t       rs1;
		reg_addr_t       rs2;
		reg_addr_t       rd;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] imm;
	} decode_data_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [31:0]     instruction;
		ctrl_t           ctrl;
		reg_addr_t       rd;
		logic [xlen-1:0] result;
		logic [xlen-1:0] store_data;
	} execute_data_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [31:0]     instruction;
		logic            regwrite;
		reg_addr_t       rd;
		logic [xlen-1:0] regdata;
	} wb_data_t;

endpackage

`default_nettype wire

//--- verilog/hazard_if.sv
`default_nettype none

interface hazard_if;

	logic               stall_front;
	logic               flush_decode;
	logic               flush_execute;
	core_pkg::fwd_sel_t fwd_a;
	core_pkg::fwd_sel_t fwd_b;

	modport hazard (
		output stall_front, flush_decode, flush_execute, fwd_a, fwd_b
	);

	modport fetch (input stall_front, flush_decode);

	modport decode (input stall_front, flush_execute);

	modport execute (input fwd_a, fwd_b);

endinterface

`default_nettype wire

//--- verilog/fetch_stage.sv
`default_nettype none

module fetch_stage #(
	parameter logic [63:0] RESET_PC = 64'h8000_0000
) (
	input  logic                        clk,
	input  logic                        reset,
	hazard_if.fetch                     hz,
	input  logic                        mem_wait,
	input  logic                        redirect,
	input  logic [core_pkg::xlen-1:0]   redirect_pc,
	output logic                        ireq_valid,
	output logic [core_pkg::xlen-1:0]   ireq_addr,
	input  logic                        iresp_data_ok,
	input  logic [31:0]                 iresp_data,
	output core_pkg::fetch_data_t       fetch_out
);

	logic [core_pkg::xlen-1:0] pc;
	logic [core_pkg::xlen-1:0] pc_next;
	logic [core_pkg::xlen-1:0] redirect_pend_pc;
	logic                      redirect_pend;
	logic                      held_valid;
	logic [31:0]               held_instr;
	logic                      fetch_done;
	logic                      have_instr;
	logic [31:0]               instr;
	logic                      advance;
	logic                      take_redirect;

	// a word returned while the front end is stalled waits in the hold register
	assign ireq_valid    = ~held_valid;
	assign ireq_addr     = pc;
	assign fetch_done    = ireq_valid & iresp_data_ok;
	assign have_instr    = held_valid | fetch_done;
	assign instr         = held_valid ? held_instr : iresp_data;
	assign advance       = ~mem_wait & ~hz.stall_front;
	assign take_redirect = redirect & ~mem_wait;

	always_comb begin
		pc_next = pc;
		if (redirect_pend) begin
			if (fetch_done)
				pc_next = redirect_pend_pc;
		end else if (take_redirect) begin
			if (have_instr)
				pc_next = redirect_pc;
		end else if (have_instr & advance) begin
			pc_next = pc + 64'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
			redirect_pend <= 1'b0;
			held_valid <= 1'b0;
			fetch_out.valid <= 1'b0;
		end else begin
			pc <= pc_next;

			// address must stay put until data_ok, so park the target
			if (redirect_pend) begin
				if (fetch_done)
					redirect_pend <= 1'b0;
			end else if (take_redirect & ~have_instr) begin
				redirect_pend <= 1'b1;
				redirect_pend_pc <= redirect_pc;
			end

			if (take_redirect | redirect_pend | advance) begin
				held_valid <= 1'b0;
			end else if (fetch_done) begin
				held_valid <= 1'b1;
				held_instr <= iresp_data;
			end

			if (~mem_wait) begin
				if (hz.flush_decode) begin
					fetch_out.valid <= 1'b0;
				end else if (~hz.stall_front) begin
					fetch_out.valid <= have_instr & ~redirect_pend;
					fetch_out.pc <= pc;
					fetch_out.instruction <= instr;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none

module decode_stage (
	input  logic                        clk,
	input  logic                        reset,
	hazard_if.decode                    hz,
	input  logic                        mem_wait,
	input  core_pkg::fetch_data_t       fetch_in,
	output core_pkg::reg_addr_t         ra1,
	output core_pkg::reg_addr_t         ra2,
	input  logic [core_pkg::xlen-1:0]   rd1,
	input  logic [core_pkg::xlen-1:0]   rd2,
	output core_pkg::decode_data_t      decode_out
);

	logic [31:0]               ins;
	core_pkg::opcode_t         opcode;
	core_pkg::ctrl_t           ctrl;
	logic [core_pkg::xlen-1:0] imm;
	logic [2:0]                funct3;
	logic                      uses_rs1;
	logic                      uses_rs2;

	assign ins    = fetch_in.instruction;
	assign funct3 = ins[14:12];

	always_comb begin
		case (ins[6:0])
			core_pkg::OP_IMM, core_pkg::OP, core_pkg::LUI, core_pkg::LOAD,
			core_pkg::STORE, core_pkg::BRANCH, core_pkg::JAL:
				opcode = core_pkg::opcode_t'(ins[6:0]);
			default:
				opcode = core_pkg::OP_NONE;
		endcase
	end

	// unsupported encodings fall out with all control bits low
	always_comb begin
		ctrl = '0;
		imm = '0;
		case (opcode)
			core_pkg::OP_IMM: begin
				ctrl.regwrite = (funct3 == 3'b000);
				ctrl.use_imm = 1'b1;
				imm = {{52{ins[31]}}, ins[31:20]};
			end
			core_pkg::OP: begin
				ctrl.regwrite = 1'b1;
				case (funct3)
					3'b000: ctrl.alu_op = ins[30] ? core_pkg::SUB : core_pkg::ADD;
					3'b111: ctrl.alu_op = core_pkg::AND;
					3'b110: ctrl.alu_op = core_pkg::OR;
					3'b100: ctrl.alu_op = core_pkg::XOR;
					default: ctrl.regwrite = 1'b0;
				endcase
			end
			core_pkg::LUI: begin
				ctrl.regwrite = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = core_pkg::PASS_B;
				imm = {{32{ins[31]}}, ins[31:12], 12'b0};
			end
			core_pkg::LOAD: begin
				ctrl.regwrite = (funct3 == 3'b011);
				ctrl.memread = (funct3 == 3'b011);
				ctrl.use_imm = 1'b1;
				imm = {{52{ins[31]}}, ins[31:20]};
			end
			core_pkg::STORE: begin
				ctrl.memwrite = (funct3 == 3'b011);
				ctrl.use_imm = 1'b1;
				imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
			end
			core_pkg::BRANCH: begin
				ctrl.branch = (funct3 == 3'b000);
				imm = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			core_pkg::JAL: begin
				ctrl.regwrite = 1'b1;
				ctrl.jump = 1'b1;
				imm = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			default: ;
		endcase
		// x0 is never a destination
		if (ins[11:7] == 5'd0)
			ctrl.regwrite = 1'b0;
	end

	assign uses_rs1 = opcode inside {core_pkg::OP_IMM, core_pkg::OP, core_pkg::LOAD,
		core_pkg::STORE, core_pkg::BRANCH};
	assign uses_rs2 = opcode inside {core_pkg::OP, core_pkg::STORE, core_pkg::BRANCH};

	assign ra1 = uses_rs1 ? ins[19:15] : 5'd0;
	assign ra2 = uses_rs2 ? ins[24:20] : 5'd0;

	always_ff @(posedge clk) begin
		if (reset) begin
			decode_out.valid <= 1'b0;
		end else if (~mem_wait) begin
			decode_out.valid <= fetch_in.valid & ~hz.flush_execute & ~hz.stall_front;
			decode_out.pc <= fetch_in.pc;
			decode_out.instruction <= ins;
			decode_out.ctrl <= ctrl;
			decode_out.rs1 <= ra1;
			decode_out.rs2 <= ra2;
			decode_out.rd <= ins[11:7];
			decode_out.rs1_data <= rd1;
			decode_out.rs2_data <= rd2;
			decode_out.imm <= imm;
		end
	end

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`default_nettype none

module regfile (
	input  logic                        clk,
	input  logic                        reset,
	input  core_pkg::reg_addr_t         ra1,
	input  core_pkg::reg_addr_t         ra2,
	output logic [core_pkg::xlen-1:0]   rd1,
	output logic [core_pkg::xlen-1:0]   rd2,
	input  logic                        wen,
	input  core_pkg::reg_addr_t         wa,
	input  logic [core_pkg::xlen-1:0]   wd
);

	logic [core_pkg::xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// same-cycle write is visible to the reader
	assign rd1 = (ra1 == 5'd0) ? '0 : (wen && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : (wen && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

module execute_stage (
	input  logic                        clk,
	input  logic                        reset,
	hazard_if.execute                   hz,
	input  logic                        mem_wait,
	input  core_pkg::decode_data_t      decode_in,
	input  logic [core_pkg::xlen-1:0]   wb_regdata,
	output logic                        redirect,
	output logic [core_pkg::xlen-1:0]   redirect_pc,
	output core_pkg::execute_data_t     execute_out
);

	logic [core_pkg::xlen-1:0] src_a;
	logic [core_pkg::xlen-1:0] rs2_val;
	logic [core_pkg::xlen-1:0] src_b;
	logic [core_pkg::xlen-1:0] alu_out;
	logic [core_pkg::xlen-1:0] pc_plus4;

	always_comb begin
		case (hz.fwd_a)
			core_pkg::FWD_MEM: src_a = execute_out.result;
			core_pkg::FWD_WB:  src_a = wb_regdata;
			default:           src_a = decode_in.rs1_data;
		endcase
		case (hz.fwd_b)
			core_pkg::FWD_MEM: rs2_val = execute_out.result;
			core_pkg::FWD_WB:  rs2_val = wb_regdata;
			default:           rs2_val = decode_in.rs2_data;
		endcase
	end

	assign src_b = decode_in.ctrl.use_imm ? decode_in.imm : rs2_val;

	always_comb begin
		case (decode_in.ctrl.alu_op)
			core_pkg::SUB:    alu_out = src_a - src_b;
			core_pkg::AND:    alu_out = src_a & src_b;
			core_pkg::OR:     alu_out = src_a | src_b;
			core_pkg::XOR:    alu_out = src_a ^ src_b;
			core_pkg::PASS_B: alu_out = src_b;
			default:          alu_out = src_a + src_b;
		endcase
	end

	// beq and jal are both pc relative
	assign redirect = decode_in.valid &
		(decode_in.ctrl.jump | (decode_in.ctrl.branch & (src_a == rs2_val)));
	assign redirect_pc = decode_in.pc + decode_in.imm;
	assign pc_plus4 = decode_in.pc + 64'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			execute_out.valid <= 1'b0;
		end else if (~mem_wait) begin
			execute_out.valid <= decode_in.valid;
			execute_out.pc <= decode_in.pc;
			execute_out.instruction <= decode_in.instruction;
			execute_out.ctrl <= decode_in.ctrl;
			execute_out.rd <= decode_in.rd;
			execute_out.result <= decode_in.ctrl.jump ? pc_plus4 : alu_out;
			execute_out.store_data <= rs2_val;
		end
	end

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`default_nettype none

module memory_stage (
	input  logic                        clk,
	input  logic                        reset,
	input  core_pkg::execute_data_t     execute_in,
	output logic                        dreq_valid,
	output logic                        dreq_write,
	output logic [core_pkg::xlen-1:0]   dreq_addr,
	output logic [core_pkg::xlen-1:0]   dreq_wdata,
	input  logic                        dresp_data_ok,
	input  logic [core_pkg::xlen-1:0]   dresp_rdata,
	output logic                        mem_wait,
	output core_pkg::wb_data_t          wb,
	output logic                        commit_valid,
	output logic [core_pkg::xlen-1:0]   commit_pc,
	output logic [31:0]                 commit_instr,
	output logic                        commit_wen,
	output core_pkg::reg_addr_t         commit_rd,
	output logic [core_pkg::xlen-1:0]   commit_wdata
);

	logic [core_pkg::xlen-1:0] regdata;

	assign dreq_valid = execute_in.valid &
		(execute_in.ctrl.memread | execute_in.ctrl.memwrite);
	assign dreq_write = execute_in.ctrl.memwrite;
	assign dreq_addr  = execute_in.result;
	assign dreq_wdata = execute_in.store_data;
	assign mem_wait   = dreq_valid & ~dresp_data_ok;

	assign regdata = execute_in.ctrl.memread ? dresp_rdata : execute_in.result;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb.valid <= 1'b0;
			wb.regwrite <= 1'b0;
		end else if (mem_wait) begin
			// bubble into writeback; rd and data stay for the forward path
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= execute_in.valid;
			wb.regwrite <= execute_in.valid & execute_in.ctrl.regwrite;
			wb.pc <= execute_in.pc;
			wb.instruction <= execute_in.instruction;
			wb.rd <= execute_in.rd;
			wb.regdata <= regdata;
		end
	end

	assign commit_valid = wb.valid;
	assign commit_pc    = wb.pc;
	assign commit_instr = wb.instruction;
	assign commit_wen   = wb.valid & wb.regwrite;
	assign commit_rd    = wb.rd;
	assign commit_wdata = wb.regdata;

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
`default_nettype none

module hazard_unit (
	hazard_if.hazard                    hz,
	input  core_pkg::decode_data_t      decode_in,
	input  core_pkg::fetch_data_t       fetch_in,
	input  core_pkg::execute_data_t     execute_out,
	input  core_pkg::wb_data_t          wb,
	input  logic                        redirect
);

	core_pkg::reg_addr_t next_rs1;
	core_pkg::reg_addr_t next_rs2;
	logic                load_use;

	// memory result first, it is the younger writer
	function automatic core_pkg::fwd_sel_t fwd_for(input core_pkg::reg_addr_t rs);
		if (rs != 5'd0 && execute_out.valid && execute_out.ctrl.regwrite &&
				!execute_out.ctrl.memread && execute_out.rd == rs)
			return core_pkg::FWD_MEM;
		if (rs != 5'd0 && wb.regwrite && wb.rd == rs)
			return core_pkg::FWD_WB;
		return core_pkg::FWD_NONE;
	endfunction

	assign hz.fwd_a = fwd_for(decode_in.rs1);
	assign hz.fwd_b = fwd_for(decode_in.rs2);

	// raw fields of the word in decode
	assign next_rs1 = fetch_in.instruction[19:15];
	assign next_rs2 = fetch_in.instruction[24:20];

	assign load_use = decode_in.valid & decode_in.ctrl.memread & decode_in.ctrl.regwrite &
		fetch_in.valid & (decode_in.rd == next_rs1 || decode_in.rd == next_rs2);

	assign hz.stall_front   = load_use;
	assign hz.flush_decode  = redirect;
	assign hz.flush_execute = redirect;

endmodule

`default_nettype wire

//--- verilog/core_top.sv
`default_nettype none

module core_top #(
	parameter logic [63:0] RESET_PC = 64'h8000_0000
) (
	input  logic        clk,
	input  logic        reset,
	output logic        ireq_valid,
	output logic [63:0] ireq_addr,
	input  logic        iresp_data_ok,
	input  logic [31:0] iresp_data,
	output logic        dreq_valid,
	output logic        dreq_write,
	output logic [63:0] dreq_addr,
	output logic [63:0] dreq_wdata,
	input  logic        dresp_data_ok,
	input  logic [63:0] dresp_rdata,
	output logic        commit_valid,
	output logic [63:0] commit_pc,
	output logic [31:0] commit_instr,
	output logic        commit_wen,
	output logic [4:0]  commit_rd,
	output logic [63:0] commit_wdata
);

	core_pkg::fetch_data_t     fetch_data;
	core_pkg::decode_data_t    decode_data;
	core_pkg::execute_data_t   execute_data;
	core_pkg::wb_data_t        wb_data;
	core_pkg::reg_addr_t       ra1;
	core_pkg::reg_addr_t       ra2;
	logic [core_pkg::xlen-1:0] rd1;
	logic [core_pkg::xlen-1:0] rd2;
	logic                      mem_wait;
	logic                      redirect;
	logic [core_pkg::xlen-1:0] redirect_pc;

	hazard_if hz ();

	fetch_stage #(
		.RESET_PC(RESET_PC)
	) fetch0 (
		.clk(clk),
		.reset(reset),
		.hz(hz.fetch),
		.mem_wait(mem_wait),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ireq_valid(ireq_valid),
		.ireq_addr(ireq_addr),
		.iresp_data_ok(iresp_data_ok),
		.iresp_data(iresp_data),
		.fetch_out(fetch_data)
	);

	decode_stage decode0 (
		.clk(clk),
		.reset(reset),
		.hz(hz.decode),
		.mem_wait(mem_wait),
		.fetch_in(fetch_data),
		.ra1(ra1),
		.ra2(ra2),
		.rd1(rd1),
		.rd2(rd2),
		.decode_out(decode_data)
	);

	regfile regfile0 (
		.clk(clk),
		.reset(reset),
		.ra1(ra1),
		.ra2(ra2),
		.rd1(rd1),
		.rd2(rd2),
		.wen(commit_wen),
		.wa(commit_rd),
		.wd(wb_data.regdata)
	);

	execute_stage execute0 (
		.clk(clk),
		.reset(reset),
		.hz(hz.execute),
		.mem_wait(mem_wait),
		.decode_in(decode_data),
		.wb_regdata(wb_data.regdata),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.execute_out(execute_data)
	);

	memory_stage memory0 (
		.clk(clk),
		.reset(reset),
		.execute_in(execute_data),
		.dreq_valid(dreq_valid),
		.dreq_write(dreq_write),
		.dreq_addr(dreq_addr),
		.dreq_wdata(dreq_wdata),
		.dresp_data_ok(dresp_data_ok),
		.dresp_rdata(dresp_rdata),
		.mem_wait(mem_wait),
		.wb(wb_data),
		.commit_valid(commit_valid),
		.commit_pc(commit_pc),
		.commit_instr(commit_instr),
		.commit_wen(commit_wen),
		.commit_rd(commit_rd),
		.commit_wdata(commit_wdata)
	);

	hazard_unit hazard0 (
		.hz(hz.hazard),
		.decode_in(decode_data),
		.fetch_in(fetch_data),
		.execute_out(execute_data),
		.wb(wb_data),
		.redirect(redirect)
	);

endmodule

`default_nettype wire

//--- sim/sim_memory.sv
`default_nettype none

module sim_memory (
	input  logic        clk,
	input  logic        reset,
	input  logic        ireq_valid,
	input  logic [63:0] ireq_addr,
	output logic        iresp_data_ok,
	output logic [31:0] iresp_data,
	input  logic        dreq_valid,
	input  logic        dreq_write,
	input  logic [63:0] dreq_addr,
	input  logic [63:0] dreq_wdata,
	output logic        dresp_data_ok,
	output logic [63:0] dresp_rdata
);

	localparam int words = 256;
	localparam int index_bits = $clog2(words);

	logic [63:0]           mem [words];
	integer                seed = 22882;
	logic [1:0]            i_delay = 2'd0;
	logic [1:0]            d_delay = 2'd0;
	logic                  i_ok = 1'b0;
	logic [31:0]           i_data = 32'd0;
	logic                  d_ok = 1'b0;
	logic [63:0]           d_data = 64'd0;
	logic [index_bits-1:0] i_index;
	logic [index_bits-1:0] d_index;

	// dword memory, upper address bits alias
	assign i_index = ireq_addr[index_bits+2:3];
	assign d_index = dreq_addr[index_bits+2:3];

	assign iresp_data_ok = i_ok;
	assign iresp_data    = i_data;
	assign dresp_data_ok = d_ok;
	assign dresp_rdata   = d_data;

	initial begin
		for (int i = 0; i < words; i++)
			mem[i] = 64'h0123_4567_89ab_cdef ^ (64'(i) * 64'h9e37_79b9_7f4a_7c15);
	end

	// responses move on the falling edge, the core takes them on the rising one
	always @(negedge clk) begin
		if (reset) begin
			i_ok <= 1'b0;
			d_ok <= 1'b0;
			i_delay <= 2'd0;
			d_delay <= 2'd0;
		end else begin
			i_ok <= 1'b0;
			if (ireq_valid) begin
				if (i_delay == 2'd0) begin
					i_ok <= 1'b1;
					i_data <= ireq_addr[2] ? mem[i_index][63:32] : mem[i_index][31:0];
					// delay for whatever request comes next
					i_delay <= 2'($random(seed));
				end else begin
					i_delay <= i_delay - 2'd1;
				end
			end

			d_ok <= 1'b0;
			if (dreq_valid) begin
				if (d_delay == 2'd0) begin
					d_ok <= 1'b1;
					if (dreq_write)
						mem[d_index] = dreq_wdata;
					else
						d_data <= mem[d_index];
					d_delay <= 2'($random(seed));
				end else begin
					d_delay <= d_delay - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/core_tb.sv
`default_nettype none

module core_tb;

	localparam logic [63:0] reset_pc = 64'h8000_0000;
	localparam logic [63:0] loop_pc = reset_pc + 64'h68;
	localparam int prog_len = 28;
	localparam int commit_count = 23;
	localparam int commit_timeout = 200;
	localparam int drain_cycles = 60;
	localparam int store0_index = 'h408 / 8;
	localparam int store1_index = 'h410 / 8;

	typedef struct packed {
		logic [63:0] pc;
		logic        wen;
		logic [4:0]  rd;
		logic [63:0] wdata;
	} commit_row_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        ireq_valid;
	logic [63:0] ireq_addr;
	logic        iresp_data_ok;
	logic [31:0] iresp_data;
	logic        dreq_valid;
	logic        dreq_write;
	logic [63:0] dreq_addr;
	logic [63:0] dreq_wdata;
	logic        dresp_data_ok;
	logic [63:0] dresp_rdata;
	logic        commit_valid;
	logic [63:0] commit_pc;
	logic [31:0] commit_instr;
	logic        commit_wen;
	logic [4:0]  commit_rd;
	logic [63:0] commit_wdata;

	logic [31:0] prog [prog_len];
	commit_row_t expected [commit_count];
	int          errors;
	int          timeouts;
	int          checked;

	always #5 clk = ~clk;

	core_top #(
		.RESET_PC(reset_pc)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.ireq_valid(ireq_valid),
		.ireq_addr(ireq_addr),
		.iresp_data_ok(iresp_data_ok),
		.iresp_data(iresp_data),
		.dreq_valid(dreq_valid),
		.dreq_write(dreq_write),
		.dreq_addr(dreq_addr),
		.dreq_wdata(dreq_wdata),
		.dresp_data_ok(dresp_data_ok),
		.dresp_rdata(dresp_rdata),
		.commit_valid(commit_valid),
		.commit_pc(commit_pc),
		.commit_instr(commit_instr),
		.commit_wen(commit_wen),
		.commit_rd(commit_rd),
		.commit_wdata(commit_wdata)
	);

	sim_memory mem0 (
		.clk(clk),
		.reset(reset),
		.ireq_valid(ireq_valid),
		.ireq_addr(ireq_addr),
		.iresp_data_ok(iresp_data_ok),
		.iresp_data(iresp_data),
		.dreq_valid(dreq_valid),
		.dreq_write(dreq_write),
		.dreq_addr(dreq_addr),
		.dreq_wdata(dreq_wdata),
		.dresp_data_ok(dresp_data_ok),
		.dresp_rdata(dresp_rdata)
	);

	task automatic fill_tables();
		prog[0] = 32'h0050_0093;   // addi x1, x0, 5
		prog[1] = 32'hffd0_0113;   // addi x2, x0, -3
		prog[2] = 32'h0020_81b3;   // add  x3, x1, x2
		prog[3] = 32'h4011_8233;   // sub  x4, x3, x1
		prog[4] = 32'h0012_72b3;   // and  x5, x4, x1
		prog[5] = 32'h0022_e333;   // or   x6, x5, x2
		prog[6] = 32'h0013_43b3;   // xor  x7, x6, x1
		prog[7] = 32'h1234_5437;   // lui  x8, 0x12345
		prog[8] = 32'h6784_0413;   // addi x8, x8, 0x678
		prog[9] = 32'h4000_0513;   // addi x10, x0, 0x400
		prog[10] = 32'h0075_3423;  // sd   x7, 8(x10)
		prog[11] = 32'h0085_3583;  // ld   x11, 8(x10)
		prog[12] = 32'h0015_8633;  // add  x12, x11, x1
		prog[13] = 32'h0085_3823;  // sd   x8, 16(x10)
		prog[14] = 32'h0105_3683;  // ld   x13, 16(x10)
		prog[15] = 32'h00d6_8733;  // add  x14, x13, x13
		prog[16] = 32'h0050_8663;  // beq  x1, x5, +12 (taken)
		prog[17] = 32'h0010_0793;  // addi x15, x0, 1
		prog[18] = 32'h0020_0793;  // addi x15, x0, 2
		prog[19] = 32'h0070_0813;  // addi x16, x0, 7
		prog[20] = 32'h0020_8463;  // beq  x1, x2, +8 (not taken)
		prog[21] = 32'h0090_0893;  // addi x17, x0, 9
		prog[22] = 32'h00c0_096f;  // jal  x18, +12
		prog[23] = 32'h0010_0993;  // addi x19, x0, 1
		prog[24] = 32'h0020_0993;  // addi x19, x0, 2
		prog[25] = 32'h0109_0a33;  // add  x20, x18, x16
		prog[26] = 32'h0000_006f;  // jal  x0, 0
		prog[27] = 32'h0000_0013;

		// pc, wen, rd, wdata in retirement order
		expected[0] = '{reset_pc + 64'h00, 1'b1, 5'd1, 64'd5};
		expected[1] = '{reset_pc + 64'h04, 1'b1, 5'd2, 64'hffff_ffff_ffff_fffd};
		expected[2] = '{reset_pc + 64'h08, 1'b1, 5'd3, 64'd2};
		expected[3] = '{reset_pc + 64'h0c, 1'b1, 5'd4, 64'hffff_ffff_ffff_fffd};
		expected[4] = '{reset_pc + 64'h10, 1'b1, 5'd5, 64'd5};
		expected[5] = '{reset_pc + 64'h14, 1'b1, 5'd6, 64'hffff_ffff_ffff_fffd};
		expected[6] = '{reset_pc + 64'h18, 1'b1, 5'd7, 64'hffff_ffff_ffff_fff8};
		expected[7] = '{reset_pc + 64'h1c, 1'b1, 5'd8, 64'h0000_0000_1234_5000};
		expected[8] = '{reset_pc + 64'h20, 1'b1, 5'd8, 64'h0000_0000_1234_5678};
		expected[9] = '{reset_pc + 64'h24, 1'b1, 5'd10, 64'h400};
		expected[10] = '{reset_pc + 64'h28, 1'b0, 5'd0, 64'd0};
		expected[11] = '{reset_pc + 64'h2c, 1'b1, 5'd11, 64'hffff_ffff_ffff_fff8};
		expected[12] = '{reset_pc + 64'h30, 1'b1, 5'd12, 64'hffff_ffff_ffff_fffd};
		expected[13] = '{reset_pc + 64'h34, 1'b0, 5'd0, 64'd0};
		expected[14] = '{reset_pc + 64'h38, 1'b1, 5'd13, 64'h0000_0000_1234_5678};
		expected[15] = '{reset_pc + 64'h3c, 1'b1, 5'd14, 64'h0000_0000_2468_acf0};
		expected[16] = '{reset_pc + 64'h40, 1'b0, 5'd0, 64'd0};
		expected[17] = '{reset_pc + 64'h4c, 1'b1, 5'd16, 64'd7};
		expected[18] = '{reset_pc + 64'h50, 1'b0, 5'd0, 64'd0};
		expected[19] = '{reset_pc + 64'h54, 1'b1, 5'd17, 64'd9};
		expected[20] = '{reset_pc + 64'h58, 1'b1, 5'd18, reset_pc + 64'h5c};
		expected[21] = '{reset_pc + 64'h64, 1'b1, 5'd20, reset_pc + 64'h63};
		expected[22] = '{loop_pc, 1'b0, 5'd0, 64'd0};
	endtask

	// two instructions per dword with the lower address in the low half
	task automatic load_program();
		for (int i = 0; i < prog_len / 2; i++)
			mem0.mem[i] = {prog[2 * i + 1], prog[2 * i]};
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] want);
		errors++;
		$display("ERROR %s: got 0x%h, expected 0x%h", name, got, want);
	endtask

	// commit outputs are registered and settle before the falling edge
	task automatic wait_commit(output logic seen);
		int waited;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < commit_timeout) begin
			@(negedge clk);
			seen = commit_valid;
			waited++;
		end
	endtask

	initial begin
		logic        seen;
		logic [31:0] want_instr;
		errors = 0;
		timeouts = 0;
		checked = 0;
		reset = 1'b1;
		fill_tables();
		@(negedge clk);
		load_program();
		@(negedge clk);
		reset = 1'b0;

		for (int n = 0; n < commit_count && timeouts == 0; n++) begin
			wait_commit(seen);
			if (!seen) begin
				timeouts++;
				$display("timeout: commit %0d did not arrive within %0d cycles", n,
					commit_timeout);
			end else begin
				checked++;
				want_instr = prog[int'((expected[n].pc - reset_pc) >> 2)];
				if (commit_pc !== expected[n].pc)
					report_mismatch("commit_pc", commit_pc, expected[n].pc);
				if (commit_instr !== want_instr)
					report_mismatch("commit_instr", 64'(commit_instr), 64'(want_instr));
				if (commit_wen !== expected[n].wen)
					report_mismatch("commit_wen", 64'(commit_wen), 64'(expected[n].wen));
				if (expected[n].wen && commit_rd !== expected[n].rd)
					report_mismatch("commit_rd", 64'(commit_rd), 64'(expected[n].rd));
				if (expected[n].wen && commit_wdata !== expected[n].wdata)
					report_mismatch("commit_wdata", commit_wdata, expected[n].wdata);
			end
		end

		// only the closing self loop may retire from here on
		if (timeouts == 0) begin
			repeat (drain_cycles) begin
				@(negedge clk);
				if (commit_valid && commit_pc !== loop_pc)
					report_mismatch("commit_pc", commit_pc, loop_pc);
			end
			// each store lands in its own dword
			if (mem0.mem[store0_index] !== 64'hffff_ffff_ffff_fff8)
				report_mismatch("mem[0x408]", mem0.mem[store0_index],
					64'hffff_ffff_ffff_fff8);
			if (mem0.mem[store1_index] !== 64'h0000_0000_1234_5678)
				report_mismatch("mem[0x410]", mem0.mem[store1_index],
					64'h0000_0000_1234_5678);
		end

		$display("%0d commits checked, %0d errors, %0d timeouts", checked, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
verilog/core_pkg.sv
verilog/hazard_if.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/hazard_unit.sv
verilog/core_top.sv
sim/sim_memory.sv
sim/core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= core_tb
RTL_TOP    ?= core_top
FILE_LIST  ?= project.f
OBJ_DIR    ?= obj_dir
BUILD_FLAGS ?= --binary -j 0
LINT_FLAGS ?= --lint-only
PASS_MSG   ?= TESTS PASSED
RTL_FILES  ?= $(filter verilog/%,$(shell cat $(FILE_LIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
